/* Bender.yml */
package:
  name: gemm_accel

export_include_dirs:
  - design

sources:
  - design/gemm_pkg.sv
  - design/matrix_buffer.sv
  - design/mm_engine.sv
  - design/dma_engine.sv
  - design/gemm_accel_top.sv
  - target: test
    files:
      - testbench/tb_axi_mem.sv
      - testbench/tb_gemm_accel.sv

/* design/dma_engine.sv */
/* dma engine of the gemm tile
   reads A and B over axi into the buffers, starts the multiply,
   writes the 16 result words back as one burst */

`timescale 1ns/1ps
`include "gemm_params.svh"

module dma_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  logic [31:0]             mat_a_addr_i,
    input  logic [31:0]             mat_b_addr_i,
    input  logic [31:0]             mat_c_addr_i,
    output logic                    done_o,
    output gemm_pkg::axi_req_t      axi_req_o,
    input  gemm_pkg::axi_rsp_t      axi_rsp_i,
    output logic                    buf_a_we_o,
    output logic [`GEMM_BUF_AW-1:0] buf_a_waddr_o,
    output gemm_pkg::row_t          buf_a_wdata_o,
    output logic                    buf_b_we_o,
    output logic [`GEMM_BUF_AW-1:0] buf_b_waddr_o,
    output gemm_pkg::row_t          buf_b_wdata_o,
    output logic                    mm_start_o,
    input  logic                    mm_done_i,
    input  gemm_pkg::acc_array_t    accum_i
);

    localparam int BEAT_W = $clog2(`GEMM_BURST_LEN);
    localparam int COL_W  = $clog2(`GEMM_SA);
    localparam int ROW_CW = `GEMM_BUF_AW + 1;
    localparam int SHIFT_W = (`GEMM_SA - 1) * `GEMM_DW;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR_A,
        S_ADDR_B,
        S_LOAD,
        S_WAIT_MM,
        S_ADDR_C,
        S_WRITE_C
    } state_t;

    state_t                  state_q;
    // job addresses, latched at start
    logic [31:0]             a_base_q;
    logic [31:0]             b_base_q;
    logic [31:0]             c_base_q;
    // row assembly, one per read id
    gemm_pkg::row_t          row_a_q;
    gemm_pkg::row_t          row_b_q;
    logic [COL_W-1:0]        beat_a_q;
    logic [COL_W-1:0]        beat_b_q;
    logic [ROW_CW-1:0]       rows_a_q;
    logic [ROW_CW-1:0]       rows_b_q;
    logic                    we_a_q;
    logic                    we_b_q;
    // result burst
    logic [BEAT_W-1:0]       wbeat_q;
    logic                    w_done_q;
    logic                    r_hs_a;
    logic                    r_hs_b;
    logic                    w_hs;
    logic                    loaded;

    // rready is high exactly in load, so a valid beat there is a handshake
    assign r_hs_a = (state_q == S_LOAD) && axi_rsp_i.r.rvalid && !axi_rsp_i.r.rid;
    assign r_hs_b = (state_q == S_LOAD) && axi_rsp_i.r.rvalid && axi_rsp_i.r.rid;
    assign w_hs   = axi_req_o.w.wvalid && axi_rsp_i.wready;
    assign loaded = (rows_a_q == ROW_CW'(`GEMM_SA)) && (rows_b_q == ROW_CW'(`GEMM_SA));

    // idle doubles as done
    assign done_o = (state_q == S_IDLE);

    always_comb begin
        axi_req_o = '0;
        // read address, A on id 0 then B on id 1
        axi_req_o.ar.arvalid = (state_q == S_ADDR_A) || (state_q == S_ADDR_B);
        axi_req_o.ar.arid    = (state_q == S_ADDR_B);
        axi_req_o.ar.araddr  = (state_q == S_ADDR_B) ? b_base_q : a_base_q;
        axi_req_o.ar.arlen   = 8'(`GEMM_BURST_LEN - 1);
        axi_req_o.ar.arsize  = 3'($clog2(`GEMM_DW / 8));
        // incr
        axi_req_o.ar.arburst = 2'b01;
        // write address for C
        axi_req_o.aw.awvalid = (state_q == S_ADDR_C);
        axi_req_o.aw.awid    = 1'b0;
        axi_req_o.aw.awaddr  = c_base_q;
        axi_req_o.aw.awlen   = 8'(`GEMM_BURST_LEN - 1);
        axi_req_o.aw.awsize  = 3'($clog2(`GEMM_DW / 8));
        axi_req_o.aw.awburst = 2'b01;
        // row-major walk over accum, low word only
        axi_req_o.w.wvalid = (state_q == S_WRITE_C) && !w_done_q;
        axi_req_o.w.wdata  = accum_i[wbeat_q[BEAT_W-1:COL_W]][wbeat_q[COL_W-1:0]][`GEMM_DW-1:0];
        axi_req_o.w.wstrb  = '1;
        axi_req_o.w.wlast  = (wbeat_q == BEAT_W'(`GEMM_BURST_LEN - 1));
        axi_req_o.rready   = (state_q == S_LOAD);
        axi_req_o.bready   = (state_q == S_WRITE_C);
    end

    // buffer write port, registered strobe one cycle after 4th beat
    assign buf_a_we_o    = we_a_q;
    assign buf_a_waddr_o = rows_a_q[`GEMM_BUF_AW-1:0];
    assign buf_a_wdata_o = row_a_q;
    assign buf_b_we_o    = we_b_q;
    assign buf_b_waddr_o = rows_b_q[`GEMM_BUF_AW-1:0];
    assign buf_b_wdata_o = row_b_q;

    // control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            beat_a_q   <= '0;
            beat_b_q   <= '0;
            rows_a_q   <= '0;
            rows_b_q   <= '0;
            we_a_q     <= 1'b0;
            we_b_q     <= 1'b0;
            wbeat_q    <= '0;
            w_done_q   <= 1'b0;
            mm_start_o <= 1'b0;
        end else begin
            we_a_q     <= r_hs_a && (beat_a_q == '1);
            we_b_q     <= r_hs_b && (beat_b_q == '1);
            mm_start_o <= 1'b0;
            if (r_hs_a) begin
                beat_a_q <= beat_a_q + 1'b1;
            end
            if (r_hs_b) begin
                beat_b_q <= beat_b_q + 1'b1;
            end
            // row address advances after each buffer write
            if (we_a_q) begin
                rows_a_q <= rows_a_q + 1'b1;
            end
            if (we_b_q) begin
                rows_b_q <= rows_b_q + 1'b1;
            end
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        beat_a_q <= '0;
                        beat_b_q <= '0;
                        rows_a_q <= '0;
                        rows_b_q <= '0;
                        state_q  <= S_ADDR_A;
                    end
                end
                S_ADDR_A: begin
                    if (axi_rsp_i.arready) begin
                        state_q <= S_ADDR_B;
                    end
                end
                S_ADDR_B: begin
                    if (axi_rsp_i.arready) begin
                        state_q <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    // both buffers full
                    if (loaded) begin
                        mm_start_o <= 1'b1;
                        state_q    <= S_WAIT_MM;
                    end
                end
                S_WAIT_MM: begin
                    if (mm_done_i) begin
                        state_q <= S_ADDR_C;
                    end
                end
                S_ADDR_C: begin
                    if (axi_rsp_i.awready) begin
                        wbeat_q  <= '0;
                        w_done_q <= 1'b0;
                        state_q  <= S_WRITE_C;
                    end
                end
                S_WRITE_C: begin
                    if (w_hs) begin
                        wbeat_q <= wbeat_q + 1'b1;
                        if (axi_req_o.w.wlast) begin
                            w_done_q <= 1'b1;
                        end
                    end
                    // response code ignored
                    if (axi_rsp_i.b.bvalid) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // addresses and row data
    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && start_i) begin
            a_base_q <= mat_a_addr_i;
            b_base_q <= mat_b_addr_i;
            c_base_q <= mat_c_addr_i;
        end
        // shift in at the bottom, first beat ends up on top
        if (r_hs_a) begin
            row_a_q <= {row_a_q[SHIFT_W-1:0], axi_rsp_i.r.rdata};
        end
        if (r_hs_b) begin
            row_b_q <= {row_b_q[SHIFT_W-1:0], axi_rsp_i.r.rdata};
        end
    end

endmodule

/* design/gemm_accel_top.sv */
/* gemm accelerator tile top
   dma engine, operand buffers A and B, multiply engine */

`timescale 1ns/1ps
`include "gemm_params.svh"

module gemm_accel_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  logic [31:0]        mat_a_addr_i,
    input  logic [31:0]        mat_b_addr_i,
    input  logic [31:0]        mat_c_addr_i,
    output logic               done_o,
    output gemm_pkg::axi_req_t axi_req_o,
    input  gemm_pkg::axi_rsp_t axi_rsp_i
);

    // dma to buffer write ports
    logic                    buf_a_we;
    logic [`GEMM_BUF_AW-1:0] buf_a_waddr;
    gemm_pkg::row_t          buf_a_wdata;
    logic                    buf_b_we;
    logic [`GEMM_BUF_AW-1:0] buf_b_waddr;
    gemm_pkg::row_t          buf_b_wdata;
    // multiply engine read side
    logic [`GEMM_BUF_AW-1:0] a_raddr;
    logic [`GEMM_BUF_AW-1:0] b_raddr;
    gemm_pkg::row_t          a_row;
    gemm_pkg::row_t          b_row;
    // handshake and results
    logic                    mm_start;
    logic                    mm_done;
    gemm_pkg::acc_array_t    accum;

    dma_engine u_dma (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .mat_a_addr_i  (mat_a_addr_i),
        .mat_b_addr_i  (mat_b_addr_i),
        .mat_c_addr_i  (mat_c_addr_i),
        .done_o        (done_o),
        .axi_req_o     (axi_req_o),
        .axi_rsp_i     (axi_rsp_i),
        .buf_a_we_o    (buf_a_we),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_we_o    (buf_b_we),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_wdata_o (buf_b_wdata),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .accum_i       (accum)
    );

    matrix_buffer u_buf_a (
        .clk     (clk),
        .we_i    (buf_a_we),
        .waddr_i (buf_a_waddr),
        .wdata_i (buf_a_wdata),
        .raddr_i (a_raddr),
        .rdata_o (a_row)
    );

    matrix_buffer u_buf_b (
        .clk     (clk),
        .we_i    (buf_b_we),
        .waddr_i (buf_b_waddr),
        .wdata_i (buf_b_wdata),
        .raddr_i (b_raddr),
        .rdata_o (b_row)
    );

    mm_engine u_mm (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mm_start),
        .done_o    (mm_done),
        .a_raddr_o (a_raddr),
        .b_raddr_o (b_raddr),
        .a_row_i   (a_row),
        .b_row_i   (b_row),
        .accum_o   (accum)
    );

endmodule

/* design/gemm_params.svh */
/* sizing macros for the gemm accelerator tile
   element width, array dimension, buffer depth, burst length */

`ifndef GEMM_PARAMS_SVH
`define GEMM_PARAMS_SVH

// element and axi data width
`define GEMM_DW        32
// matrix dimension, rows and columns
`define GEMM_SA        4
// row address width of each operand buffer
`define GEMM_BUF_AW    2
// beats per matrix, one element per beat
`define GEMM_BURST_LEN 16
// full product plus one guard bit
`define GEMM_ACC_W     65

`endif

/* design/gemm_pkg.sv */
/* shared types of the gemm accelerator
   element, buffer row, accumulator array, axi channel structs */

`include "gemm_params.svh"

package gemm_pkg;

    typedef logic signed [`GEMM_DW-1:0] elem_t;
    // element 0 (first beat) in the top word
    typedef logic [`GEMM_SA*`GEMM_DW-1:0] row_t;
    typedef logic signed [`GEMM_ACC_W-1:0] acc_t;
    // [row][col]
    typedef acc_t [`GEMM_SA-1:0][`GEMM_SA-1:0] acc_array_t;

    typedef struct packed {
        logic        arvalid;
        logic        arid;
        logic [31:0] araddr;
        logic [7:0]  arlen;
        logic [2:0]  arsize;
        logic [1:0]  arburst;
    } axi_ar_t;

    typedef struct packed {
        logic        awvalid;
        logic        awid;
        logic [31:0] awaddr;
        logic [7:0]  awlen;
        logic [2:0]  awsize;
        logic [1:0]  awburst;
    } axi_aw_t;

    typedef struct packed {
        logic                   wvalid;
        logic [`GEMM_DW-1:0]    wdata;
        logic [`GEMM_DW/8-1:0]  wstrb;
        logic                   wlast;
    } axi_w_t;

    typedef struct packed {
        logic                rvalid;
        logic                rid;
        logic [`GEMM_DW-1:0] rdata;
        logic                rlast;
    } axi_r_t;

    typedef struct packed {
        logic       bvalid;
        logic [1:0] bresp;
    } axi_b_t;

    // accelerator to memory
    typedef struct packed {
        axi_ar_t ar;
        axi_aw_t aw;
        axi_w_t  w;
        logic    rready;
        logic    bready;
    } axi_req_t;

    // memory to accelerator
    typedef struct packed {
        axi_r_t r;
        axi_b_t b;
        logic   arready;
        logic   awready;
        logic   wready;
    } axi_rsp_t;

endpackage

/* design/matrix_buffer.sv */
/* operand row memory, one write port and one registered read port
   holds one 4x4 matrix as four 128-bit rows */

`timescale 1ns/1ps
`include "gemm_params.svh"

module matrix_buffer (
    input  logic                    clk,
    input  logic                    we_i,
    input  logic [`GEMM_BUF_AW-1:0] waddr_i,
    input  gemm_pkg::row_t          wdata_i,
    input  logic [`GEMM_BUF_AW-1:0] raddr_i,
    output gemm_pkg::row_t          rdata_o
);

    // row storage
    gemm_pkg::row_t mem_q [2**`GEMM_BUF_AW];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rdata_o <= mem_q[raddr_i];
    end

endmodule

/* design/mm_engine.sv */
/* sequential 4x4 matrix multiply
   one A element times a B row per step, 16 steps, accumulator array */

`timescale 1ns/1ps
`include "gemm_params.svh"

module mm_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    output logic                    done_o,
    output logic [`GEMM_BUF_AW-1:0] a_raddr_o,
    output logic [`GEMM_BUF_AW-1:0] b_raddr_o,
    input  gemm_pkg::row_t          a_row_i,
    input  gemm_pkg::row_t          b_row_i,
    output gemm_pkg::acc_array_t    accum_o
);

    localparam int STEP_W    = 2 * `GEMM_BUF_AW;
    localparam int LAST_STEP = `GEMM_SA * `GEMM_SA - 1;

    // read side, step = {i, k}
    logic                         busy_q;
    logic [STEP_W-1:0]            rd_step_q;
    // mac side, one cycle behind the read address
    logic                         mac_vld_q;
    logic [STEP_W-1:0]            mac_step_q;
    logic [`GEMM_BUF_AW-1:0]      mac_i;
    logic [`GEMM_BUF_AW-1:0]      mac_k;
    gemm_pkg::elem_t              a_elem;
    gemm_pkg::elem_t              b_elem [`GEMM_SA];
    logic signed [2*`GEMM_DW-1:0] prod [`GEMM_SA];
    gemm_pkg::acc_array_t         acc_q;

    // A row i, B row k
    assign a_raddr_o = rd_step_q[STEP_W-1:`GEMM_BUF_AW];
    assign b_raddr_o = rd_step_q[`GEMM_BUF_AW-1:0];
    assign mac_i     = mac_step_q[STEP_W-1:`GEMM_BUF_AW];
    assign mac_k     = mac_step_q[`GEMM_BUF_AW-1:0];

    // A[i][k] against all four B[k][j]
    always_comb begin
        a_elem = a_row_i[(`GEMM_SA - 1 - mac_k) * `GEMM_DW +: `GEMM_DW];
        for (int j = 0; j < `GEMM_SA; j++) begin
            b_elem[j] = b_row_i[(`GEMM_SA - 1 - j) * `GEMM_DW +: `GEMM_DW];
            prod[j]   = a_elem * b_elem[j];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            rd_step_q  <= '0;
            mac_vld_q  <= 1'b0;
            mac_step_q <= '0;
            done_o     <= 1'b0;
        end else begin
            mac_vld_q  <= busy_q;
            mac_step_q <= rd_step_q;
            // pulse with the last accumulate
            done_o     <= mac_vld_q && (mac_step_q == STEP_W'(LAST_STEP));
            if (start_i) begin
                busy_q    <= 1'b1;
                rd_step_q <= '0;
            end else if (busy_q) begin
                // wraps back to 0 after the last step
                rd_step_q <= rd_step_q + 1'b1;
                if (rd_step_q == STEP_W'(LAST_STEP)) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // accumulators, cleared per job and held after done
    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q <= '0;
        end else if (mac_vld_q) begin
            for (int j = 0; j < `GEMM_SA; j++) begin
                acc_q[mac_i][j] <= acc_q[mac_i][j] + prod[j];
            end
        end
    end

    assign accum_o = acc_q;

endmodule

/* sim.f */
+incdir+design
design/gemm_pkg.sv
design/matrix_buffer.sv
design/mm_engine.sv
design/dma_engine.sv
design/gemm_accel_top.sv
testbench/tb_axi_mem.sv
testbench/tb_gemm_accel.sv

/* testbench/tb_axi_mem.sv */
/* axi memory model for the gemm testbench
   word array, random ready and valid stalls, interleaved read ids */

`timescale 1ns/1ps
`include "gemm_params.svh"

module tb_axi_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  gemm_pkg::axi_req_t axi_req_i,
    output gemm_pkg::axi_rsp_t axi_rsp_o
);

    // 4 KiB of words
    logic [31:0] mem [0:1023];
    integer      seed;
    // one open read burst per id
    logic        rd_act [2];
    logic [9:0]  rd_idx [2];
    int          rd_cnt [2];
    logic [9:0]  wr_idx;
    int          wr_cnt;
    logic        b_pend;

    // background pattern, every address bit shows up
    initial begin : mem_fill
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h6d00_0000 ^ (i << 12) ^ i;
        end
    end

    initial begin : mem_proc
        gemm_pkg::axi_req_t req;
        logic               run;
        logic               ar_hs;
        logic               r_hs;
        logic               aw_hs;
        logic               w_hs;
        logic               b_hs;
        int                 id;
        seed      = 75192;
        axi_rsp_o = '0;
        rd_act[0] = 1'b0;
        rd_act[1] = 1'b0;
        b_pend    = 1'b0;
        forever begin
            // sample mid cycle, act just after the next edge
            @(negedge clk);
            run   = rst_n;
            req   = axi_req_i;
            ar_hs = req.ar.arvalid && axi_rsp_o.arready;
            r_hs  = axi_rsp_o.r.rvalid && req.rready;
            aw_hs = req.aw.awvalid && axi_rsp_o.awready;
            w_hs  = req.w.wvalid && axi_rsp_o.wready;
            b_hs  = axi_rsp_o.b.bvalid && req.bready;
            @(posedge clk);
            #1;
            if (!run) begin
                axi_rsp_o = '0;
                rd_act[0] = 1'b0;
                rd_act[1] = 1'b0;
                b_pend    = 1'b0;
            end else begin
                if (ar_hs) begin
                    rd_act[req.ar.arid] = 1'b1;
                    rd_idx[req.ar.arid] = req.ar.araddr[11:2];
                    rd_cnt[req.ar.arid] = 0;
                end
                // beat taken, close the burst after 16
                if (r_hs) begin
                    id         = axi_rsp_o.r.rid;
                    rd_cnt[id] = rd_cnt[id] + 1;
                    if (rd_cnt[id] == `GEMM_BURST_LEN) begin
                        rd_act[id] = 1'b0;
                    end
                    axi_rsp_o.r.rvalid = 1'b0;
                end
                if (aw_hs) begin
                    wr_idx = req.aw.awaddr[11:2];
                    wr_cnt = 0;
                end
                if (w_hs) begin
                    mem[wr_idx + wr_cnt] = req.w.wdata;
                    wr_cnt = wr_cnt + 1;
                    if (req.w.wlast) begin
                        b_pend = 1'b1;
                    end
                end
                if (b_hs) begin
                    axi_rsp_o.b.bvalid = 1'b0;
                end
                // next read beat from a random open id, sometimes none
                if (!axi_rsp_o.r.rvalid && (($random(seed) & 3) != 0)) begin
                    id = $random(seed) & 1;
                    if (!rd_act[id]) begin
                        id = 1 - id;
                    end
                    if (rd_act[id]) begin
                        axi_rsp_o.r.rvalid = 1'b1;
                        axi_rsp_o.r.rid    = id[0];
                        axi_rsp_o.r.rdata  = mem[rd_idx[id] + rd_cnt[id]];
                        axi_rsp_o.r.rlast  = (rd_cnt[id] == `GEMM_BURST_LEN - 1);
                    end
                end
                // write response after a random delay
                if (b_pend && !axi_rsp_o.b.bvalid && (($random(seed) & 1) != 0)) begin
                    axi_rsp_o.b.bvalid = 1'b1;
                    axi_rsp_o.b.bresp  = 2'b00;
                    b_pend             = 1'b0;
                end
                axi_rsp_o.arready = (($random(seed) & 3) != 0);
                axi_rsp_o.awready = (($random(seed) & 3) != 0);
                axi_rsp_o.wready  = (($random(seed) & 3) != 0);
            end
        end
    end

endmodule

/* testbench/tb_gemm_accel.sv */
/* testbench for the gemm accelerator tile
   clock and reset, random jobs, reference matrix multiply,
   axi bus monitor, compare tasks with timeouts */

`timescale 1ns/1ps
`include "gemm_params.svh"

module tb_gemm_accel;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic [31:0]        a_addr;
    logic [31:0]        b_addr;
    logic [31:0]        c_addr;
    logic               done;
    gemm_pkg::axi_req_t axi_req;
    gemm_pkg::axi_rsp_t axi_rsp;
    integer             seed;
    // expected C, row-major
    gemm_pkg::elem_t    exp_c [`GEMM_BURST_LEN];
    gemm_pkg::axi_ar_t  ar_log [$];
    gemm_pkg::axi_aw_t  aw_log [$];
    gemm_pkg::axi_ar_t  ar_prev;
    logic               ar_wait;
    logic               b_prev;
    // high from the start sample until the B handshake
    logic               busy;
    int                 w_seen;

    gemm_accel_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .mat_a_addr_i (a_addr),
        .mat_b_addr_i (b_addr),
        .mat_c_addr_i (c_addr),
        .done_o       (done),
        .axi_req_o    (axi_req),
        .axi_rsp_i    (axi_rsp)
    );

    tb_axi_mem u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .axi_req_i (axi_req),
        .axi_rsp_o (axi_rsp)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_elem(input string name, input gemm_pkg::elem_t got,
                              input gemm_pkg::elem_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_ar(input string name, input gemm_pkg::axi_ar_t got,
                            input gemm_pkg::axi_ar_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_aw(input string name, input gemm_pkg::axi_aw_t got,
                              input gemm_pkg::axi_aw_t exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic expect_strobe(input string name, input logic [`GEMM_DW/8-1:0] got,
                                 input logic [`GEMM_DW/8-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // mostly random, with the signed extremes mixed in
    function automatic gemm_pkg::elem_t rand_elem();
        case ($random(seed) & 7)
            0: rand_elem = 32'h8000_0000;
            1: rand_elem = 32'h7fff_ffff;
            2: rand_elem = 32'hffff_ffff;
            default: rand_elem = $random(seed);
        endcase
    endfunction

    // bus monitor, sampled mid cycle when everything has settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (ar_wait) begin
                check_ar("axi_req_o.ar", axi_req.ar, ar_prev);
            end
            ar_wait = axi_req.ar.arvalid && !axi_rsp.arready;
            ar_prev = axi_req.ar;
            if (axi_req.ar.arvalid && axi_rsp.arready) begin
                ar_log.push_back(axi_req.ar);
            end
            if (axi_req.aw.awvalid && axi_rsp.awready) begin
                aw_log.push_back(axi_req.aw);
            end
            if (axi_req.w.wvalid && axi_rsp.wready) begin
                if (w_seen >= `GEMM_BURST_LEN) begin
                    $display("more than 16 W beats in one job");
                    stop_on_error();
                end
                check_elem("axi_req_o.w.wdata", axi_req.w.wdata, exp_c[w_seen]);
                // full words only
                expect_strobe("axi_req_o.w.wstrb", axi_req.w.wstrb, '1);
                expect_bit("axi_req_o.w.wlast", axi_req.w.wlast, w_seen == 15);
                w_seen = w_seen + 1;
            end
            // done back one cycle after B, low while busy
            if (b_prev) begin
                expect_bit("done_o", done, 1'b1);
            end else if (busy) begin
                expect_bit("done_o", done, 1'b0);
            end
            b_prev = axi_req.bready && axi_rsp.b.bvalid;
            if (b_prev) begin
                busy = 1'b0;
            end
        end
    end

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (!(done && !busy)) begin
            if (cycles == 2000) begin
                $display("timeout waiting for done_o after start_i");
                stop_on_error();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic run_job();
        int                a_slot;
        int                b_slot;
        int                c_slot;
        int                acc;
        gemm_pkg::elem_t   a_m [`GEMM_BURST_LEN];
        gemm_pkg::elem_t   b_m [`GEMM_BURST_LEN];
        gemm_pkg::axi_ar_t ar_exp;
        gemm_pkg::axi_aw_t aw_exp;
        // 64 slots of 16 words, offsets 1..32 keep all three apart
        a_slot = $random(seed) & 63;
        b_slot = (a_slot + 1 + ($random(seed) & 15)) & 63;
        c_slot = (a_slot + 17 + ($random(seed) & 15)) & 63;
        for (int n = 0; n < `GEMM_BURST_LEN; n++) begin
            a_m[n] = rand_elem();
            b_m[n] = rand_elem();
            u_mem.mem[a_slot * 16 + n] = a_m[n];
            u_mem.mem[b_slot * 16 + n] = b_m[n];
        end
        // 32-bit products and sums wrap to the same low word
        for (int r = 0; r < `GEMM_SA; r++) begin
            for (int c = 0; c < `GEMM_SA; c++) begin
                acc = 0;
                for (int k = 0; k < `GEMM_SA; k++) begin
                    acc = acc + a_m[4 * r + k] * b_m[4 * k + c];
                end
                exp_c[4 * r + c] = acc;
            end
        end
        // stale C never matches
        for (int n = 0; n < `GEMM_BURST_LEN; n++) begin
            u_mem.mem[c_slot * 16 + n] = ~exp_c[n];
        end
        ar_log.delete();
        aw_log.delete();
        w_seen = 0;
        @(posedge clk);
        #1;
        start  = 1'b1;
        a_addr = a_slot * 64;
        b_addr = b_slot * 64;
        c_addr = c_slot * 64;
        @(posedge clk);
        #1;
        start = 1'b0;
        busy  = 1'b1;
        wait_for_done();
        if (ar_log.size() != 2 || aw_log.size() != 1 || w_seen != `GEMM_BURST_LEN) begin
            $display("wrong number of AR, AW or W transfers in a job");
            stop_on_error();
        end
        ar_exp         = '0;
        ar_exp.arvalid = 1'b1;
        ar_exp.araddr  = a_addr;
        ar_exp.arlen   = 8'd15;
        ar_exp.arsize  = 3'd2;
        ar_exp.arburst = 2'b01;
        check_ar("axi_req_o.ar", ar_log[0], ar_exp);
        ar_exp.arid    = 1'b1;
        ar_exp.araddr  = b_addr;
        check_ar("axi_req_o.ar", ar_log[1], ar_exp);
        aw_exp         = '0;
        aw_exp.awvalid = 1'b1;
        aw_exp.awaddr  = c_addr;
        aw_exp.awlen   = 8'd15;
        aw_exp.awsize  = 3'd2;
        aw_exp.awburst = 2'b01;
        compare_aw("axi_req_o.aw", aw_log[0], aw_exp);
        // result words landed at the C base, in order
        for (int n = 0; n < `GEMM_BURST_LEN; n++) begin
            check_elem("u_mem.mem", u_mem.mem[c_slot * 16 + n], exp_c[n]);
        end
    endtask

    initial begin
        seed    = 75192;
        rst_n   = 1'b0;
        start   = 1'b0;
        a_addr  = '0;
        b_addr  = '0;
        c_addr  = '0;
        busy    = 1'b0;
        ar_wait = 1'b0;
        b_prev  = 1'b0;
        w_seen  = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // idle outputs right after reset
        @(negedge clk);
        expect_bit("done_o", done, 1'b1);
        expect_bit("axi_req_o.ar.arvalid", axi_req.ar.arvalid, 1'b0);
        expect_bit("axi_req_o.aw.awvalid", axi_req.aw.awvalid, 1'b0);
        expect_bit("axi_req_o.w.wvalid", axi_req.w.wvalid, 1'b0);
        expect_bit("axi_req_o.rready", axi_req.rready, 1'b0);
        expect_bit("axi_req_o.bready", axi_req.bready, 1'b0);
        // back-to-back jobs
        for (int job = 0; job < 20; job++) begin
            run_job();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule
